// ==== ex_pkg.sv ====
package ex_pkg;

    // ==================================================
    // Default widths
    // ==================================================
    localparam int DEF_WORD_WIDTH      = 16;
    localparam int DEF_PC_WIDTH        = 12;
    localparam int DEF_PMEM_ADDR_WIDTH = 12;
    localparam int DEF_DMEM_ADDR_WIDTH = 12;
    localparam int DEF_REG_IDX_WIDTH   = 4;
    // Byte step from one instruction word to the next
    localparam int DEF_PC_INCREMENT    = 2;

    // ==================================================
    // Opcodes from the decode stage
    // ==================================================
    typedef enum logic [3:0] {
        alu_none, alu_add, alu_mul, alu_sll, alu_srl,
        alu_sra, alu_and, alu_or, alu_xor, alu_pass
    } alu_op_e;

    // Conditions are tested on the ALU result
    typedef enum logic [2:0] {
        br_none, br_jump, br_eq0, br_gt0, br_lt0
    } branch_cond_e;

    typedef enum logic [2:0] {
        mem_none,
        mem_load_word,
        mem_load_byte_signed,
        mem_load_byte_unsigned,
        mem_store_word,
        mem_store_byte
    } mem_op_e;

endpackage

// ==== ex_input_regs.sv ====
`timescale 1ns/1ns

module ex_input_regs #(
    parameter int word_width    = ex_pkg::DEF_WORD_WIDTH,
    parameter int pc_width      = ex_pkg::DEF_PC_WIDTH,
    parameter int reg_idx_width = ex_pkg::DEF_REG_IDX_WIDTH
) (
    input  logic                       clock,
    input  logic                       reset,
    input  ex_pkg::alu_op_e            alu_op,
    input  logic                       neg_src2,
    input  ex_pkg::branch_cond_e       branch_cond,
    input  logic                       second_cycle,
    input  ex_pkg::mem_op_e            mem_op,
    input  logic                       incr_pc_is_res,
    input  logic                       write_res,
    input  logic [reg_idx_width-1:0]   res_reg_idx,
    input  logic [pc_width-1:0]        pc,
    input  logic [word_width-1:0]      src1,
    input  logic [word_width-1:0]      src2,
    input  logic [word_width-1:0]      src3,
    input  logic                       flush,
    input  logic                       in_bubble,
    output ex_pkg::alu_op_e            alu_op_q,
    output logic                       neg_src2_q,
    output ex_pkg::branch_cond_e       branch_cond_q,
    output logic                       second_cycle_q,
    output ex_pkg::mem_op_e            mem_op_q,
    output logic                       incr_pc_is_res_q,
    output logic                       write_res_q,
    output logic [reg_idx_width-1:0]   res_reg_idx_q,
    output logic [pc_width-1:0]        pc_q,
    output logic [word_width-1:0]      src1_q,
    output logic [word_width-1:0]      src2_q,
    output logic [word_width-1:0]      src3_q,
    output logic                       bubble
);

    // Raw sampled copies of the fields that a flush masks
    ex_pkg::alu_op_e            alu_op_r;
    ex_pkg::branch_cond_e       branch_cond_r;
    ex_pkg::mem_op_e            mem_op_r;
    logic                       incr_pc_is_res_r;
    logic                       write_res_r;
    logic [reg_idx_width-1:0]   res_reg_idx_r;
    logic [pc_width-1:0]        pc_r;
    logic                       flush_q;
    logic                       in_bubble_q;

    // ==================================================
    // Sample decode-stage outputs
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_op_r         <= ex_pkg::alu_none;
            neg_src2_q       <= 1'b0;
            branch_cond_r    <= ex_pkg::br_none;
            second_cycle_q   <= 1'b0;
            mem_op_r         <= ex_pkg::mem_none;
            incr_pc_is_res_r <= 1'b0;
            write_res_r      <= 1'b0;
            res_reg_idx_r    <= '0;
            pc_r             <= '0;
            src1_q           <= '0;
            src2_q           <= '0;
            src3_q           <= '0;
            flush_q          <= 1'b0;
            in_bubble_q      <= 1'b0;
        end else begin
            alu_op_r         <= alu_op;
            neg_src2_q       <= neg_src2;
            branch_cond_r    <= branch_cond;
            second_cycle_q   <= second_cycle;
            mem_op_r         <= mem_op;
            incr_pc_is_res_r <= incr_pc_is_res;
            write_res_r      <= write_res;
            res_reg_idx_r    <= res_reg_idx;
            pc_r             <= pc;
            src1_q           <= src1;
            src2_q           <= src2;
            src3_q           <= src3;
            flush_q          <= flush;
            in_bubble_q      <= in_bubble;
        end
    end

    // ==================================================
    // Flush turns this cycle into a bubble
    // ==================================================
    always_comb begin
        alu_op_q         = flush_q ? ex_pkg::alu_none : alu_op_r;
        branch_cond_q    = flush_q ? ex_pkg::br_none  : branch_cond_r;
        mem_op_q         = flush_q ? ex_pkg::mem_none : mem_op_r;
        incr_pc_is_res_q = incr_pc_is_res_r & ~flush_q;
        write_res_q      = write_res_r & ~flush_q;
        res_reg_idx_q    = flush_q ? '0 : res_reg_idx_r;
        pc_q             = flush_q ? '0 : pc_r;
    end

    assign bubble = in_bubble_q | flush_q;

endmodule

// ==== ex_alu.sv ====
`timescale 1ns/1ns

module ex_alu #(
    parameter int word_width = ex_pkg::DEF_WORD_WIDTH
) (
    input  ex_pkg::alu_op_e         alu_op,
    input  logic                    neg_src2,
    input  logic [word_width-1:0]   src1,
    input  logic [word_width-1:0]   src2,
    output logic [word_width-1:0]   alu_res
);

    // Second operand, negated for subtract
    logic [word_width-1:0] operand2;

    assign operand2 = neg_src2 ? (~src2 + 1'b1) : src2;

    // ==================================================
    // Operation select
    // ==================================================
    always_comb begin
        case (alu_op)
            ex_pkg::alu_add:  alu_res = src1 + operand2;
            // Low half of the product only
            ex_pkg::alu_mul:  alu_res = src1 * operand2;
            ex_pkg::alu_sll:  alu_res = src1 << operand2;
            ex_pkg::alu_srl:  alu_res = src1 >> operand2;
            // Sign bit fills from the left
            ex_pkg::alu_sra:  alu_res = $signed(src1) >>> operand2;
            ex_pkg::alu_and:  alu_res = src1 & operand2;
            ex_pkg::alu_or:   alu_res = src1 | operand2;
            ex_pkg::alu_xor:  alu_res = src1 ^ operand2;
            ex_pkg::alu_pass: alu_res = operand2;
            default:          alu_res = '0;
        endcase
    end

endmodule

// ==== ex_branch_unit.sv ====
`timescale 1ns/1ns

module ex_branch_unit #(
    parameter int word_width      = ex_pkg::DEF_WORD_WIDTH,
    parameter int pmem_addr_width = ex_pkg::DEF_PMEM_ADDR_WIDTH
) (
    input  logic                         clock,
    input  logic                         reset,
    input  ex_pkg::branch_cond_e         branch_cond,
    input  logic                         second_cycle,
    input  logic [word_width-1:0]        alu_res,
    output logic                         set_pc,
    output logic                         flush_if,
    output logic                         flush_dc_ex,
    output logic [pmem_addr_width-1:0]   branch_pc
);

    // ALU result from the previous cycle
    logic [word_width-1:0] alu_res_prev;
    logic                  cond_now;
    logic                  cond_prev;

    function automatic logic cond_holds(
        input ex_pkg::branch_cond_e  cond,
        input logic [word_width-1:0] value
    );
        logic is_zero;
        logic is_neg;
        is_zero = (value == '0);
        is_neg  = value[word_width-1];
        case (cond)
            ex_pkg::br_eq0: cond_holds = is_zero;
            ex_pkg::br_gt0: cond_holds = !is_neg && !is_zero;
            ex_pkg::br_lt0: cond_holds = is_neg;
            default:        cond_holds = 1'b0;
        endcase
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_res_prev <= '0;
        end else begin
            alu_res_prev <= alu_res;
        end
    end

    assign cond_now  = cond_holds(branch_cond, alu_res);
    assign cond_prev = cond_holds(branch_cond, alu_res_prev);

    // ==================================================
    // Jump and branch decision
    // ==================================================
    always_comb begin
        set_pc      = 1'b0;
        flush_if    = 1'b0;
        flush_dc_ex = 1'b0;
        branch_pc   = '0;
        if (branch_cond == ex_pkg::br_jump) begin
            set_pc      = 1'b1;
            flush_if    = 1'b1;
            flush_dc_ex = 1'b1;
            branch_pc   = alu_res[pmem_addr_width-1:0];
        end else if (!second_cycle && cond_now) begin
            // Target still to come, stop fetch only
            flush_if = 1'b1;
        end else if (second_cycle && cond_prev) begin
            set_pc      = 1'b1;
            flush_if    = 1'b1;
            flush_dc_ex = 1'b1;
            branch_pc   = alu_res[pmem_addr_width-1:0];
        end
    end

endmodule

// ==== ex_mem_result.sv ====
`timescale 1ns/1ns

module ex_mem_result #(
    parameter int word_width      = ex_pkg::DEF_WORD_WIDTH,
    parameter int pc_width        = ex_pkg::DEF_PC_WIDTH,
    parameter int dmem_addr_width = ex_pkg::DEF_DMEM_ADDR_WIDTH,
    parameter int pc_increment    = ex_pkg::DEF_PC_INCREMENT
) (
    input  ex_pkg::mem_op_e              mem_op,
    input  logic                         incr_pc_is_res,
    input  logic [pc_width-1:0]          pc,
    input  logic [word_width-1:0]        alu_res,
    input  logic [word_width-1:0]        src3,
    output logic [dmem_addr_width-1:0]   dmem_rd_addr,
    output logic [dmem_addr_width-1:0]   dmem_wr_addr,
    output logic [word_width-1:0]        dmem_wr_word,
    output logic [word_width-1:0]        res
);

    localparam logic [pc_width-1:0] pc_step = pc_increment[pc_width-1:0];

    logic [pc_width-1:0] pc_next;

    // Address and store data
    always_comb begin
        dmem_rd_addr = '0;
        dmem_wr_addr = '0;
        dmem_wr_word = '0;
        case (mem_op)
            ex_pkg::mem_load_word,
            ex_pkg::mem_load_byte_signed,
            ex_pkg::mem_load_byte_unsigned: dmem_rd_addr = alu_res[dmem_addr_width-1:0];
            ex_pkg::mem_store_word,
            ex_pkg::mem_store_byte: begin
                dmem_wr_addr = alu_res[dmem_addr_width-1:0];
                dmem_wr_word = src3;
            end
            default: ;
        endcase
    end

    // Return address for calls
    assign pc_next = pc + pc_step;
    assign res     = incr_pc_is_res ? {{(word_width-pc_width){1'b0}}, pc_next} : alu_res;

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage #(
    parameter int word_width      = ex_pkg::DEF_WORD_WIDTH,
    parameter int pc_width        = ex_pkg::DEF_PC_WIDTH,
    parameter int pmem_addr_width = ex_pkg::DEF_PMEM_ADDR_WIDTH,
    parameter int dmem_addr_width = ex_pkg::DEF_DMEM_ADDR_WIDTH,
    parameter int reg_idx_width   = ex_pkg::DEF_REG_IDX_WIDTH,
    parameter int pc_increment    = ex_pkg::DEF_PC_INCREMENT
) (
    input  logic                         clock,
    input  logic                         reset,
    input  ex_pkg::alu_op_e              alu_op,
    input  logic                         neg_src2,
    input  ex_pkg::branch_cond_e         branch_cond,
    input  logic                         second_cycle,
    input  ex_pkg::mem_op_e              mem_op,
    input  logic                         incr_pc_is_res,
    input  logic                         write_res,
    input  logic [reg_idx_width-1:0]     res_reg_idx,
    input  logic [pc_width-1:0]          pc,
    input  logic [word_width-1:0]        src1,
    input  logic [word_width-1:0]        src2,
    input  logic [word_width-1:0]        src3,
    input  logic                         flush,
    input  logic                         in_bubble,
    output logic                         bubble,
    output logic                         set_pc,
    output logic                         flush_if,
    output logic                         flush_dc_ex,
    output logic [pmem_addr_width-1:0]   branch_pc,
    output logic [dmem_addr_width-1:0]   dmem_rd_addr,
    output logic [dmem_addr_width-1:0]   dmem_wr_addr,
    output logic [word_width-1:0]        dmem_wr_word,
    output logic [word_width-1:0]        res,
    output ex_pkg::mem_op_e              mem_op_out,
    output logic                         write_res_out,
    output logic [reg_idx_width-1:0]     res_reg_idx_out
);

    // Registered operation
    ex_pkg::alu_op_e        alu_op_q;
    logic                   neg_src2_q;
    ex_pkg::branch_cond_e   branch_cond_q;
    logic                   second_cycle_q;
    logic                   incr_pc_is_res_q;
    logic [pc_width-1:0]    pc_q;
    logic [word_width-1:0]  src1_q;
    logic [word_width-1:0]  src2_q;
    logic [word_width-1:0]  src3_q;
    logic [word_width-1:0]  alu_res;

    ex_input_regs #(
        .word_width    (word_width),
        .pc_width      (pc_width),
        .reg_idx_width (reg_idx_width)
    ) u_input_regs (
        .clock            (clock),
        .reset            (reset),
        .alu_op           (alu_op),
        .neg_src2         (neg_src2),
        .branch_cond      (branch_cond),
        .second_cycle     (second_cycle),
        .mem_op           (mem_op),
        .incr_pc_is_res   (incr_pc_is_res),
        .write_res        (write_res),
        .res_reg_idx      (res_reg_idx),
        .pc               (pc),
        .src1             (src1),
        .src2             (src2),
        .src3             (src3),
        .flush            (flush),
        .in_bubble        (in_bubble),
        .alu_op_q         (alu_op_q),
        .neg_src2_q       (neg_src2_q),
        .branch_cond_q    (branch_cond_q),
        .second_cycle_q   (second_cycle_q),
        .mem_op_q         (mem_op_out),
        .incr_pc_is_res_q (incr_pc_is_res_q),
        .write_res_q      (write_res_out),
        .res_reg_idx_q    (res_reg_idx_out),
        .pc_q             (pc_q),
        .src1_q           (src1_q),
        .src2_q           (src2_q),
        .src3_q           (src3_q),
        .bubble           (bubble)
    );

    ex_alu #(
        .word_width (word_width)
    ) u_alu (
        .alu_op   (alu_op_q),
        .neg_src2 (neg_src2_q),
        .src1     (src1_q),
        .src2     (src2_q),
        .alu_res  (alu_res)
    );

    ex_branch_unit #(
        .word_width      (word_width),
        .pmem_addr_width (pmem_addr_width)
    ) u_branch_unit (
        .clock        (clock),
        .reset        (reset),
        .branch_cond  (branch_cond_q),
        .second_cycle (second_cycle_q),
        .alu_res      (alu_res),
        .set_pc       (set_pc),
        .flush_if     (flush_if),
        .flush_dc_ex  (flush_dc_ex),
        .branch_pc    (branch_pc)
    );

    ex_mem_result #(
        .word_width      (word_width),
        .pc_width        (pc_width),
        .dmem_addr_width (dmem_addr_width),
        .pc_increment    (pc_increment)
    ) u_mem_result (
        .mem_op         (mem_op_out),
        .incr_pc_is_res (incr_pc_is_res_q),
        .pc             (pc_q),
        .alu_res        (alu_res),
        .src3           (src3_q),
        .dmem_rd_addr   (dmem_rd_addr),
        .dmem_wr_addr   (dmem_wr_addr),
        .dmem_wr_word   (dmem_wr_word),
        .res            (res)
    );

endmodule

// ==== ex_stage_checker.sv ====
`timescale 1ns/1ns

module ex_stage_checker #(
    parameter int word_width      = ex_pkg::DEF_WORD_WIDTH,
    parameter int pc_width        = ex_pkg::DEF_PC_WIDTH,
    parameter int pmem_addr_width = ex_pkg::DEF_PMEM_ADDR_WIDTH,
    parameter int dmem_addr_width = ex_pkg::DEF_DMEM_ADDR_WIDTH,
    parameter int reg_idx_width   = ex_pkg::DEF_REG_IDX_WIDTH,
    parameter int pc_increment    = ex_pkg::DEF_PC_INCREMENT
) (
    input logic                         clock,
    input logic                         reset,
    input ex_pkg::alu_op_e              alu_op,
    input logic                         neg_src2,
    input ex_pkg::branch_cond_e         branch_cond,
    input logic                         second_cycle,
    input ex_pkg::mem_op_e              mem_op,
    input logic                         incr_pc_is_res,
    input logic                         write_res,
    input logic [reg_idx_width-1:0]     res_reg_idx,
    input logic [pc_width-1:0]          pc,
    input logic [word_width-1:0]        src1,
    input logic [word_width-1:0]        src2,
    input logic [word_width-1:0]        src3,
    input logic                         flush,
    input logic                         in_bubble,
    input logic                         bubble,
    input logic                         set_pc,
    input logic                         flush_if,
    input logic                         flush_dc_ex,
    input logic [pmem_addr_width-1:0]   branch_pc,
    input logic [dmem_addr_width-1:0]   dmem_rd_addr,
    input logic [dmem_addr_width-1:0]   dmem_wr_addr,
    input logic [word_width-1:0]        dmem_wr_word,
    input logic [word_width-1:0]        res,
    input ex_pkg::mem_op_e              mem_op_out,
    input logic                         write_res_out,
    input logic [reg_idx_width-1:0]     res_reg_idx_out
);

    int fail_count = 0;

    // Expected view of the operation offered this cycle
    logic [word_width-1:0]        in_alu;
    ex_pkg::branch_cond_e         in_cond;
    ex_pkg::mem_op_e              in_mem;
    logic                         in_load;
    logic                         in_store;
    logic [pmem_addr_width-1:0]   in_target;
    logic [dmem_addr_width-1:0]   exp_rd_addr;
    logic [dmem_addr_width-1:0]   exp_wr_addr;
    logic [word_width-1:0]        exp_wr_word;
    logic [pc_width-1:0]          pc_next;
    logic [word_width-1:0]        exp_pc_res;

    // ==================================================
    // Reference rules
    // ==================================================
    function automatic logic [word_width-1:0] alu_model(
        input ex_pkg::alu_op_e       op,
        input logic                  negate,
        input logic [word_width-1:0] a,
        input logic [word_width-1:0] b
    );
        logic [word_width-1:0]   opb;
        logic [2*word_width-1:0] ext;
        opb = negate ? ({word_width{1'b0}} - b) : b;
        ext = {{word_width{a[word_width-1]}}, a} >> opb;
        case (op)
            ex_pkg::alu_add:  return a + opb;
            ex_pkg::alu_mul:  return a * opb;
            ex_pkg::alu_sll:  return a << opb;
            ex_pkg::alu_srl:  return a >> opb;
            // Large shift amounts leave only copies of the sign
            ex_pkg::alu_sra:  return ((opb >> $clog2(word_width)) != '0) ?
                                  {word_width{a[word_width-1]}} : ext[word_width-1:0];
            ex_pkg::alu_and:  return a & opb;
            ex_pkg::alu_or:   return a | opb;
            ex_pkg::alu_xor:  return a ^ opb;
            ex_pkg::alu_pass: return opb;
            default:          return '0;
        endcase
    endfunction

    function automatic logic cond_met(
        input ex_pkg::branch_cond_e  cond,
        input logic [word_width-1:0] value
    );
        case (cond)
            ex_pkg::br_eq0: return value == '0;
            ex_pkg::br_gt0: return $signed(value) > 0;
            ex_pkg::br_lt0: return $signed(value) < 0;
            default:        return 1'b0;
        endcase
    endfunction

    // Strobes as {set_pc, flush_if, flush_dc_ex}
    function automatic logic [2:0] strobes_model(
        input ex_pkg::branch_cond_e  cond,
        input logic                  second,
        input logic [word_width-1:0] now_value,
        input logic [word_width-1:0] prev_value
    );
        if (cond == ex_pkg::br_jump) begin
            return 3'b111;
        end
        if (!second) begin
            return cond_met(cond, now_value) ? 3'b010 : 3'b000;
        end
        return cond_met(cond, prev_value) ? 3'b111 : 3'b000;
    endfunction

    always_comb begin
        in_alu  = flush ? '0 : alu_model(alu_op, neg_src2, src1, src2);
        in_cond = flush ? ex_pkg::br_none : branch_cond;
        in_mem  = flush ? ex_pkg::mem_none : mem_op;
    end

    assign in_load = in_mem inside {ex_pkg::mem_load_word, ex_pkg::mem_load_byte_signed,
                                    ex_pkg::mem_load_byte_unsigned};
    assign in_store    = in_mem inside {ex_pkg::mem_store_word, ex_pkg::mem_store_byte};
    assign in_target   = in_alu[pmem_addr_width-1:0];
    assign exp_rd_addr = in_load ? in_alu[dmem_addr_width-1:0] : '0;
    assign exp_wr_addr = in_store ? in_alu[dmem_addr_width-1:0] : '0;
    assign exp_wr_word = in_store ? src3 : '0;
    assign pc_next     = pc + pc_width'(pc_increment);
    assign exp_pc_res  = {{(word_width-pc_width){1'b0}}, pc_next};

    // ==================================================
    // Checks, one cycle after the inputs
    // ==================================================
    a_alu_result: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) && !$past(flush) && !$past(incr_pc_is_res) |-> res == $past(in_alu))
    else begin
        fail_count++;
        $error("[FAIL] %0t ALU result differs from expected", $time);
    end

    a_branch: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) && !$past(reset, 2) |->
        {set_pc, flush_if, flush_dc_ex} == strobes_model($past(in_cond),
            $past(second_cycle), $past(in_alu), $past(in_alu, 2))
        && (!set_pc || branch_pc == $past(in_target)))
    else begin
        fail_count++;
        $error("[FAIL] %0t jump or branch strobes or target wrong", $time);
    end

    a_memory: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |->
        dmem_rd_addr == $past(exp_rd_addr) && dmem_wr_addr == $past(exp_wr_addr)
        && dmem_wr_word == $past(exp_wr_word) && mem_op_out == $past(in_mem))
    else begin
        fail_count++;
        $error("[FAIL] %0t data memory address, store data or mem_op_out wrong", $time);
    end

    a_incr_pc: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) && !$past(flush) && $past(incr_pc_is_res) |-> res == $past(exp_pc_res))
    else begin
        fail_count++;
        $error("[FAIL] %0t incremented PC result wrong", $time);
    end

    a_flush: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) && $past(flush) |->
        bubble && !set_pc && !flush_if && !flush_dc_ex && !write_res_out
        && res == '0 && mem_op_out == ex_pkg::mem_none)
    else begin
        fail_count++;
        $error("[FAIL] %0t flushed cycle is not a clean bubble", $time);
    end

    // Write-back fields and bubble follow the registered inputs
    a_writeback: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |->
        write_res_out == ($past(write_res) && !$past(flush))
        && res_reg_idx_out == ($past(flush) ? '0 : $past(res_reg_idx))
        && bubble == ($past(in_bubble) || $past(flush)))
    else begin
        fail_count++;
        $error("[FAIL] %0t write-back fields or bubble wrong", $time);
    end

    // Covers the reset cycles and the first cycle after release
    a_reset: assert property (@(posedge clock)
        $past(reset) |->
        !set_pc && !flush_if && !flush_dc_ex && !write_res_out && !bubble
        && mem_op_out == ex_pkg::mem_none)
    else begin
        fail_count++;
        $error("[FAIL] %0t control output active during or right after reset", $time);
    end

endmodule

// ==== ex_stage_tb.sv ====
`timescale 1ns/1ns

module ex_stage_tb;

    localparam int word_width    = ex_pkg::DEF_WORD_WIDTH;
    localparam int pc_width      = ex_pkg::DEF_PC_WIDTH;
    localparam int pmem_width    = ex_pkg::DEF_PMEM_ADDR_WIDTH;
    localparam int dmem_width    = ex_pkg::DEF_DMEM_ADDR_WIDTH;
    localparam int reg_idx_width = ex_pkg::DEF_REG_IDX_WIDTH;
    localparam int clock_period  = 8;
    localparam int reset_cycles  = 16;
    localparam int test_cycles   = 2000;

    logic                       clock;
    logic                       reset;
    ex_pkg::alu_op_e            alu_op;
    logic                       neg_src2;
    ex_pkg::branch_cond_e       branch_cond;
    logic                       second_cycle;
    ex_pkg::mem_op_e            mem_op;
    logic                       incr_pc_is_res;
    logic                       write_res;
    logic [reg_idx_width-1:0]   res_reg_idx;
    logic [pc_width-1:0]        pc;
    logic [word_width-1:0]      src1;
    logic [word_width-1:0]      src2;
    logic [word_width-1:0]      src3;
    logic                       flush;
    logic                       in_bubble;
    logic                       bubble;
    logic                       set_pc;
    logic                       flush_if;
    logic                       flush_dc_ex;
    logic [pmem_width-1:0]      branch_pc;
    logic [dmem_width-1:0]      dmem_rd_addr;
    logic [dmem_width-1:0]      dmem_wr_addr;
    logic [word_width-1:0]      dmem_wr_word;
    logic [word_width-1:0]      res;
    ex_pkg::mem_op_e            mem_op_out;
    logic                       write_res_out;
    logic [reg_idx_width-1:0]   res_reg_idx_out;

    integer                     seed;
    int                         timeout_count = 0;
    logic [31:0]                rnd;
    // First half of a conditional branch seen last cycle
    logic                       branch_pending;
    ex_pkg::branch_cond_e       pending_cond;

    ex_stage DUT (.*);

    bind ex_stage ex_stage_checker u_checker (.*);

    always #(clock_period / 2) clock = ~clock;

    task automatic drive_idle();
        alu_op         = ex_pkg::alu_none;
        neg_src2       = 1'b0;
        branch_cond    = ex_pkg::br_none;
        second_cycle   = 1'b0;
        mem_op         = ex_pkg::mem_none;
        incr_pc_is_res = 1'b0;
        write_res      = 1'b0;
        res_reg_idx    = '0;
        pc             = '0;
        src1           = '0;
        src2           = '0;
        src3           = '0;
        flush          = 1'b0;
        in_bubble      = 1'b0;
    endtask

    task automatic drive_random();
        rnd            = $random(seed);
        alu_op         = ex_pkg::alu_op_e'(4'(rnd[7:0] % 10));
        neg_src2       = rnd[8];
        mem_op         = ex_pkg::mem_op_e'(3'(rnd[15:9] % 6));
        incr_pc_is_res = (rnd[18:16] == 3'd0);
        write_res      = rnd[19];
        res_reg_idx    = rnd[23:20];
        flush          = (rnd[26:24] == 3'd0);
        in_bubble      = (rnd[31:27] == 5'd0);
        rnd            = $random(seed);
        src1           = rnd[15:0];
        src2           = rnd[31:16];
        rnd            = $random(seed);
        src3           = rnd[15:0];
        pc             = rnd[27:16];
        // Equal operands make zero results common
        if (rnd[29:28] == 2'd0) begin
            src2 = src1;
        end
        rnd = $random(seed);
        if (branch_pending && rnd[2:0] != 3'd0) begin
            branch_cond  = pending_cond;
            second_cycle = 1'b1;
        end else begin
            branch_cond  = ex_pkg::branch_cond_e'(3'(rnd[7:3] % 5));
            second_cycle = rnd[8] & rnd[9];
        end
        branch_pending = !flush && !second_cycle && (branch_cond inside
                         {ex_pkg::br_eq0, ex_pkg::br_gt0, ex_pkg::br_lt0});
        pending_cond   = branch_cond;
    endtask

    task automatic finish_run();
        int failures;
        failures = DUT.u_checker.fail_count;
        $display("Assertion failures: %0d, timeouts: %0d", failures, timeout_count);
        if (failures == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // ==================================================
    // Reset, then random operations
    // ==================================================
    initial begin
        seed           = 57656;
        branch_pending = 1'b0;
        pending_cond   = ex_pkg::br_none;
        clock          = 1'b0;
        reset          = 1'b1;
        drive_idle();
        @(posedge clock);
        #1;
        // Busy inputs while reset must keep every register clear
        for (int i = 1; i < reset_cycles; i++) begin
            drive_random();
            @(posedge clock);
            #1;
        end
        reset          = 1'b0;
        branch_pending = 1'b0;
        for (int i = 0; i < test_cycles; i++) begin
            drive_random();
            @(posedge clock);
            #1;
        end
        drive_idle();
        repeat (4) @(posedge clock);
        finish_run();
    end

    // Watchdog
    initial begin
        #((reset_cycles + test_cycles + 20) * clock_period);
        timeout_count++;
        $display("Timeout: the run did not reach its end in the expected time");
        finish_run();
    end

endmodule

// ==== src.f ====
ex_pkg.sv
ex_input_regs.sv
ex_alu.sv
ex_branch_unit.sv
ex_mem_result.sv
ex_stage.sv
ex_stage_checker.sv
ex_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ex_stage_tb
FILELIST  = src.f
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
